// ==== rdma_resp_settings.svh ====
`ifndef RDMA_RESP_SETTINGS_SVH
`define RDMA_RESP_SETTINGS_SVH

// stream geometry
`define AXIS_DATA_W 512
`define AXIS_KEEP_W 64

`define RESP_HDR_BYTES 58
`define RD_RESP_PAYLOAD_BYTES 256
`define ETH_HDR_BYTES 14
`define IPV4_HDR_BYTES 20

`define QP_TABLE_DEPTH 8
`define QP_IDX_W 3

`define ETHERTYPE_IPV4 16'h0800
`define IPV4_VER_IHL 8'h45
`define IPV4_TOS 8'hb8
`define IPV4_ID 16'h5555
`define IPV4_FLAGS 16'h4000      // don't fragment
`define IPV4_TTL 8'hba
`define IPV4_PROTO_UDP 8'h11

`define ROCE_UDP_SPORT 16'h6851
`define ROCE_UDP_DPORT 16'd4791

`define BTH_OP_RD_RESP_ONLY 8'h10
`define BTH_OP_ACK 8'h11
`define BTH_PKEY 16'h666f

`endif

// ==== rdma_pkt_pkg.sv ====
`include "rdma_resp_settings.svh"

package rdma_pkt_pkg;

  typedef enum logic [0:0] {
    PKT_RD_RESP = 1'b0,
    PKT_ACK     = 1'b1
  } pkt_kind_t;

  // field view for the builder, byte view for the segmenter
  // bytes[RESP_HDR_BYTES-1] is the first byte on the wire
  typedef union packed {
    struct packed {
      logic [47:0] eth_dst;
      logic [47:0] eth_src;
      logic [15:0] eth_type;
      logic [7:0]  ip_ver_ihl;
      logic [7:0]  ip_tos;
      logic [15:0] ip_total_len;
      logic [15:0] ip_id;
      logic [15:0] ip_flags;
      logic [7:0]  ip_ttl;
      logic [7:0]  ip_proto;
      logic [15:0] ip_csum;
      logic [31:0] ip_src;
      logic [31:0] ip_dst;
      logic [15:0] udp_sport;
      logic [15:0] udp_dport;
      logic [15:0] udp_len;
      logic [15:0] udp_csum;
      logic [7:0]  bth_opcode;
      logic [7:0]  bth_flags;
      logic [15:0] bth_pkey;
      logic [7:0]  bth_rsvd_qp;
      logic [23:0] bth_dest_qp;
      logic [7:0]  bth_rsvd_psn;
      logic [23:0] bth_psn;
      logic [31:0] aeth;
    } fields;
    logic [`RESP_HDR_BYTES-1:0][7:0] bytes;
  } resp_hdr_u;

endpackage

// ==== resp_hdr_if.sv ====
interface resp_hdr_if;
  import rdma_pkt_pkg::*;

  logic      hdr_valid;
  logic      hdr_ready;
  resp_hdr_u hdr;
  pkt_kind_t kind;  // selects payload and length in the segmenter

  modport builder (
    output hdr_valid,
    output hdr,
    output kind,
    input  hdr_ready
  );

  modport segmenter (
    input  hdr_valid,
    input  hdr,
    input  kind,
    output hdr_ready
  );

endinterface

// ==== qp_context_table.sv ====
`include "rdma_resp_settings.svh"

module qp_context_table (
  input  logic                 core_clk,
  input  logic                 core_aresetn,
  input  logic                 wr_en_i,
  input  logic [`QP_IDX_W-1:0] wr_idx_i,
  input  logic [47:0]          wr_mac_i,
  input  logic [31:0]          wr_ip_i,
  input  logic [`QP_IDX_W-1:0] rd_idx_i,
  output logic [47:0]          rd_mac_o,
  output logic [31:0]          rd_ip_o
);

  logic [47:0] mac_q [`QP_TABLE_DEPTH];
  logic [31:0] ip_q  [`QP_TABLE_DEPTH];

  // small enough to keep in flops, cleared so unconfigured QPs read zero
  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      for (int i = 0; i < `QP_TABLE_DEPTH; i++) begin
        mac_q[i] <= '0;
        ip_q[i]  <= '0;
      end
    end else if (wr_en_i) begin
      mac_q[wr_idx_i] <= wr_mac_i;
      ip_q[wr_idx_i]  <= wr_ip_i;
    end
  end

  assign rd_mac_o = mac_q[rd_idx_i];  // async read
  assign rd_ip_o  = ip_q[rd_idx_i];

endmodule

// ==== ipv4_checksum.sv ====
`include "rdma_resp_settings.svh"

module ipv4_checksum (
  input  logic [15:0] ip_len_i,
  input  logic [31:0] src_ip_i,
  input  logic [31:0] dst_ip_i,
  output logic [15:0] csum_o
);

  logic [19:0] sum;
  logic [16:0] fold1;
  logic [15:0] fold2;

  // ten header words, checksum word counted as zero
  assign sum = 20'({`IPV4_VER_IHL, `IPV4_TOS}) +
               20'(ip_len_i) +
               20'(`IPV4_ID) +
               20'(`IPV4_FLAGS) +
               20'({`IPV4_TTL, `IPV4_PROTO_UDP}) +
               20'(src_ip_i[31:16]) +
               20'(src_ip_i[15:0]) +
               20'(dst_ip_i[31:16]) +
               20'(dst_ip_i[15:0]);

  assign fold1 = 17'(sum[15:0]) + 17'(sum[19:16]);
  assign fold2 = fold1[15:0] + 16'(fold1[16]);  // second fold cannot carry again

  assign csum_o = ~fold2;

endmodule

// ==== resp_hdr_builder.sv ====
`include "rdma_resp_settings.svh"

module resp_hdr_builder (
  input  logic                      core_clk,
  input  logic                      core_aresetn,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic [`AXIS_DATA_W-1:0]   req_data_i,
  input  logic                      req_last_i,
  input  rdma_pkt_pkg::pkt_kind_t   req_kind_i,
  input  logic                      cfg_we_i,
  input  logic [`QP_IDX_W-1:0]      cfg_qp_i,
  input  logic [47:0]               cfg_mac_i,
  input  logic [31:0]               cfg_ip_i,
  input  logic [47:0]               src_mac_i,
  input  logic [31:0]               src_ip_i,
  resp_hdr_if.builder               hdr_o
);
  import rdma_pkt_pkg::*;

  localparam int RD_PKT_BYTES = `RESP_HDR_BYTES + `RD_RESP_PAYLOAD_BYTES;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DRAIN,
    S_HOLD
  } state_t;

  state_t      state_q;
  logic        req_fire;
  logic [23:0] qp_q;
  logic [23:0] psn_q;
  pkt_kind_t   kind_q;
  logic [23:0] qp_sel;
  logic [23:0] psn_sel;
  pkt_kind_t   kind_sel;
  logic [47:0] ctx_mac;
  logic [31:0] ctx_ip;
  logic [15:0] ip_len;
  logic [15:0] udp_len;
  logic [15:0] ip_csum;
  resp_hdr_u   hdr_nxt;
  resp_hdr_u   hdr_q;

  assign req_ready_o = (state_q != S_HOLD);
  assign req_fire    = req_valid_i && req_ready_o;

  // descriptor fields live on the first beat only
  always_comb begin
    if (state_q == S_IDLE) begin
      qp_sel   = {req_data_i[47*8 +: 8], req_data_i[48*8 +: 8], req_data_i[49*8 +: 8]};
      psn_sel  = {req_data_i[51*8 +: 8], req_data_i[52*8 +: 8], req_data_i[53*8 +: 8]};
      kind_sel = req_kind_i;
    end else begin
      qp_sel   = qp_q;
      psn_sel  = psn_q;
      kind_sel = kind_q;
    end
  end

  qp_context_table u_ctx (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .wr_en_i      (cfg_we_i),
    .wr_idx_i     (cfg_qp_i),
    .wr_mac_i     (cfg_mac_i),
    .wr_ip_i      (cfg_ip_i),
    .rd_idx_i     (qp_sel[`QP_IDX_W-1:0]),
    .rd_mac_o     (ctx_mac),
    .rd_ip_o      (ctx_ip)
  );

  assign ip_len  = (kind_sel == PKT_RD_RESP) ? 16'(RD_PKT_BYTES - `ETH_HDR_BYTES) :
                                               16'(`RESP_HDR_BYTES - `ETH_HDR_BYTES);
  assign udp_len = ip_len - 16'(`IPV4_HDR_BYTES);

  ipv4_checksum u_csum (
    .ip_len_i (ip_len),
    .src_ip_i (src_ip_i),
    .dst_ip_i (ctx_ip),
    .csum_o   (ip_csum)
  );

  always_comb begin
    hdr_nxt.fields.eth_dst      = ctx_mac;
    hdr_nxt.fields.eth_src      = src_mac_i;
    hdr_nxt.fields.eth_type     = `ETHERTYPE_IPV4;
    hdr_nxt.fields.ip_ver_ihl   = `IPV4_VER_IHL;
    hdr_nxt.fields.ip_tos       = `IPV4_TOS;
    hdr_nxt.fields.ip_total_len = ip_len;
    hdr_nxt.fields.ip_id        = `IPV4_ID;
    hdr_nxt.fields.ip_flags     = `IPV4_FLAGS;
    hdr_nxt.fields.ip_ttl       = `IPV4_TTL;
    hdr_nxt.fields.ip_proto     = `IPV4_PROTO_UDP;
    hdr_nxt.fields.ip_csum      = ip_csum;
    hdr_nxt.fields.ip_src       = src_ip_i;
    hdr_nxt.fields.ip_dst       = ctx_ip;
    hdr_nxt.fields.udp_sport    = `ROCE_UDP_SPORT;
    hdr_nxt.fields.udp_dport    = `ROCE_UDP_DPORT;
    hdr_nxt.fields.udp_len      = udp_len;
    hdr_nxt.fields.udp_csum     = 16'h0000;  // unused for roce v2
    hdr_nxt.fields.bth_opcode   = (kind_sel == PKT_RD_RESP) ? `BTH_OP_RD_RESP_ONLY : `BTH_OP_ACK;
    hdr_nxt.fields.bth_flags    = 8'h00;
    hdr_nxt.fields.bth_pkey     = `BTH_PKEY;
    hdr_nxt.fields.bth_rsvd_qp  = 8'h00;
    hdr_nxt.fields.bth_dest_qp  = qp_sel;
    hdr_nxt.fields.bth_rsvd_psn = 8'h00;
    hdr_nxt.fields.bth_psn      = psn_sel;
    hdr_nxt.fields.aeth         = 32'h0000_0000;
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (req_fire) state_q <= req_last_i ? S_HOLD : S_DRAIN;
        S_DRAIN: if (req_fire && req_last_i) state_q <= S_HOLD;  // trailing beats dropped
        S_HOLD:  if (hdr_o.hdr_ready) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_fire && state_q == S_IDLE) begin
      qp_q   <= qp_sel;
      psn_q  <= psn_sel;
      kind_q <= kind_sel;
    end
    if (req_fire && req_last_i) hdr_q <= hdr_nxt;  // frozen until handoff
  end

  assign hdr_o.hdr_valid = (state_q == S_HOLD);
  assign hdr_o.hdr       = hdr_q;
  assign hdr_o.kind      = kind_q;

endmodule

// ==== beat_segmenter.sv ====
`include "rdma_resp_settings.svh"

module beat_segmenter (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  resp_hdr_if.segmenter           hdr_i,
  output logic [`AXIS_DATA_W-1:0] tx_tdata_o,
  output logic [`AXIS_KEEP_W-1:0] tx_tkeep_o,
  output logic                    tx_tvalid_o,
  output logic                    tx_tlast_o,
  input  logic                    tx_tready_i
);
  import rdma_pkt_pkg::*;

  localparam int RD_PKT_BYTES = `RESP_HDR_BYTES + `RD_RESP_PAYLOAD_BYTES;
  localparam int IMG_BEATS    = (RD_PKT_BYTES + `AXIS_KEEP_W - 1) / `AXIS_KEEP_W;
  localparam int IMG_BYTES    = IMG_BEATS * `AXIS_KEEP_W;
  localparam int BEAT_W       = $clog2(IMG_BEATS);
  localparam int LEN_W        = $clog2(IMG_BYTES + 1);
  localparam int LANE_W       = $clog2(`AXIS_KEEP_W);
  localparam int PSN_LSB_BYTE = 53;  // last byte of the bth psn

  logic                                    busy_q;
  logic [BEAT_W-1:0]                       beat_q;
  logic [LEN_W-1:0]                        rem_q;
  logic [IMG_BEATS-1:0][`AXIS_DATA_W-1:0]  img_q;
  logic [IMG_BYTES-1:0][7:0]               img_nxt;
  logic [7:0]                              psn_lsb;
  logic [LEN_W-1:0]                        pkt_len;
  logic                                    last_beat;
  logic                                    beat_fire;
  logic                                    hdr_fire;

  assign last_beat = (rem_q <= LEN_W'(`AXIS_KEEP_W));
  assign beat_fire = busy_q && tx_tready_i;

  // next header may land on the same edge as the final beat
  assign hdr_i.hdr_ready = !busy_q || (beat_fire && last_beat);
  assign hdr_fire        = hdr_i.hdr_valid && hdr_i.hdr_ready;

  assign pkt_len = (hdr_i.kind == PKT_RD_RESP) ? LEN_W'(RD_PKT_BYTES) :
                                                 LEN_W'(`RESP_HDR_BYTES);
  assign psn_lsb = hdr_i.hdr.bytes[`RESP_HDR_BYTES-1-PSN_LSB_BYTE];

  // packet byte k ends up in img_nxt[k]
  always_comb begin
    for (int k = 0; k < IMG_BYTES; k++) begin
      img_nxt[k] = 8'h00;
    end
    for (int k = 0; k < `RESP_HDR_BYTES; k++) begin
      img_nxt[k] = hdr_i.hdr.bytes[`RESP_HDR_BYTES-1-k];
    end
    if (hdr_i.kind == PKT_RD_RESP) begin
      for (int k = `RESP_HDR_BYTES; k < RD_PKT_BYTES; k++) begin
        img_nxt[k] = psn_lsb;
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      busy_q <= 1'b0;
      beat_q <= '0;
      rem_q  <= '0;
    end else if (hdr_fire) begin
      busy_q <= 1'b1;
      beat_q <= '0;
      rem_q  <= pkt_len;
    end else if (beat_fire) begin
      if (last_beat) begin
        busy_q <= 1'b0;
      end else begin
        beat_q <= beat_q + 1'b1;
        rem_q  <= rem_q - LEN_W'(`AXIS_KEEP_W);
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (hdr_fire) img_q <= img_nxt;
  end

  // all outputs come from state, so they hold while stalled
  assign tx_tvalid_o = busy_q;
  assign tx_tlast_o  = busy_q && last_beat;
  assign tx_tdata_o  = img_q[beat_q];
  assign tx_tkeep_o  = (rem_q >= LEN_W'(`AXIS_KEEP_W)) ? '1 :
                       ((`AXIS_KEEP_W'(1) << rem_q[LANE_W-1:0]) - `AXIS_KEEP_W'(1));

endmodule

// ==== rdma_resp_pkt_gen_top.sv ====
`include "rdma_resp_settings.svh"

module rdma_resp_pkt_gen_top (
  input  logic                    core_clk,
  input  logic                    core_aresetn,
  // descriptors from the wqe processor
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic [`AXIS_DATA_W-1:0] req_data_i,
  input  logic                    req_last_i,
  input  logic                    req_kind_i,
  // context table writes
  input  logic                    cfg_we_i,
  input  logic [`QP_IDX_W-1:0]    cfg_qp_i,
  input  logic [47:0]             cfg_mac_i,
  input  logic [31:0]             cfg_ip_i,
  input  logic [47:0]             src_mac_i,
  input  logic [31:0]             src_ip_i,
  output logic [`AXIS_DATA_W-1:0] tx_tdata_o,
  output logic [`AXIS_KEEP_W-1:0] tx_tkeep_o,
  output logic                    tx_tvalid_o,
  output logic                    tx_tlast_o,
  input  logic                    tx_tready_i
);
  import rdma_pkt_pkg::*;

  resp_hdr_if hdr_if ();

  resp_hdr_builder u_builder (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_data_i   (req_data_i),
    .req_last_i   (req_last_i),
    .req_kind_i   (pkt_kind_t'(req_kind_i)),  // 0 read response, 1 ack
    .cfg_we_i     (cfg_we_i),
    .cfg_qp_i     (cfg_qp_i),
    .cfg_mac_i    (cfg_mac_i),
    .cfg_ip_i     (cfg_ip_i),
    .src_mac_i    (src_mac_i),
    .src_ip_i     (src_ip_i),
    .hdr_o        (hdr_if.builder)
  );

  beat_segmenter u_segmenter (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .hdr_i        (hdr_if.segmenter),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o),
    .tx_tready_i  (tx_tready_i)
  );

endmodule

// ==== rdma_resp_pkt_gen_asserts.sv ====
`include "rdma_resp_settings.svh"

module rdma_resp_pkt_gen_assert_chk (
  input logic                    core_clk,
  input logic                    core_aresetn,
  input logic                    req_ready_o,
  input logic [`AXIS_DATA_W-1:0] tx_tdata_o,
  input logic [`AXIS_KEEP_W-1:0] tx_tkeep_o,
  input logic                    tx_tvalid_o,
  input logic                    tx_tlast_o,
  input logic                    tx_tready_i
);

  // a stalled beat stays put until the sink takes it
  a_stall_hold : assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_tvalid_o && !tx_tready_i |=> tx_tvalid_o && $stable(tx_tdata_o) &&
                                    $stable(tx_tkeep_o) && $stable(tx_tlast_o))
    else $error("output beat changed or dropped while stalled");

  // keep+1 is a power of two when lanes run from 0 without holes
  a_keep_contig : assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_tvalid_o |-> tx_tkeep_o[0] &&
                    (((tx_tkeep_o + `AXIS_KEEP_W'(1)) & tx_tkeep_o) == '0))
    else $error("tkeep lanes not contiguous from lane 0");

  a_ready_after_reset : assert property (@(posedge core_clk)
    $rose(core_aresetn) |-> req_ready_o)
    else $error("request port not ready after reset");

endmodule

bind rdma_resp_pkt_gen_top rdma_resp_pkt_gen_assert_chk u_assert_chk (.*);

// ==== tb_rdma_resp_pkt_gen.sv ====
`include "rdma_resp_settings.svh"

module tb_rdma_resp_pkt_gen;

  localparam int NUM_CASES = 8;
  localparam logic [47:0] SRC_MAC = 48'h0a0b_0c0d_0e0f;
  localparam logic [31:0] SRC_IP  = 32'h0a00_0001;

  logic                    core_clk;
  logic                    core_aresetn;
  logic                    req_valid_i;
  logic                    req_ready_o;
  logic [`AXIS_DATA_W-1:0] req_data_i;
  logic                    req_last_i;
  logic                    req_kind_i;
  logic                    cfg_we_i;
  logic [`QP_IDX_W-1:0]    cfg_qp_i;
  logic [47:0]             cfg_mac_i;
  logic [31:0]             cfg_ip_i;
  logic [47:0]             src_mac_i;
  logic [31:0]             src_ip_i;
  logic [`AXIS_DATA_W-1:0] tx_tdata_o;
  logic [`AXIS_KEEP_W-1:0] tx_tkeep_o;
  logic                    tx_tvalid_o;
  logic                    tx_tlast_o;
  logic                    tx_tready_i;

  // kind 0 is a read response and kind 1 an ack
  string       case_name [NUM_CASES];
  logic        case_kind [NUM_CASES];
  logic [23:0] case_qp [NUM_CASES];
  logic [23:0] case_psn [NUM_CASES];
  int          case_beats [NUM_CASES];
  logic [47:0] case_mac [NUM_CASES];
  logic [31:0] case_ip [NUM_CASES];
  int          ncases = 0;

  logic [7:0]  exp_bytes [320];
  int          exp_len;
  int          errors = 0;
  int          pkt_idx = 0;
  int          beat_idx = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [31:0] req_seed = 32'd9413;
  logic [31:0] rdy_seed = 32'd9413;
  logic [`AXIS_DATA_W-1:0] exp_data;
  logic [`AXIS_DATA_W-1:0] lane_mask;
  logic [`AXIS_KEEP_W-1:0] exp_keep;
  logic                    exp_last;
  int                      base;
  int                      nlanes;

  rdma_resp_pkt_gen_top dut_i (.*);

  initial core_clk = 1'b0;
  always #50 core_clk = ~core_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic compare_value(input string name, input logic [511:0] exp_v,
                               input logic [511:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("mismatch %s: expected %0h, actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic add_case(input string name, input logic kind, input logic [23:0] qp,
                          input logic [23:0] psn, input int beats, input logic [47:0] mac,
                          input logic [31:0] ip);
    case_name[ncases]  = name;
    case_kind[ncases]  = kind;
    case_qp[ncases]    = qp;
    case_psn[ncases]   = psn;
    case_beats[ncases] = beats;
    case_mac[ncases]   = mac;
    case_ip[ncases]    = ip;
    ncases++;
  endtask

  // checksum slot counts as zero among the ten header words
  function automatic logic [15:0] ip_checksum(input logic [15:0] len, input logic [31:0] dip);
    logic [15:0] words [10];
    logic [31:0] s;
    words = '{{`IPV4_VER_IHL, `IPV4_TOS}, len, `IPV4_ID, `IPV4_FLAGS,
              {`IPV4_TTL, `IPV4_PROTO_UDP}, 16'h0000, SRC_IP[31:16], SRC_IP[15:0],
              dip[31:16], dip[15:0]};
    s = '0;
    for (int w = 0; w < 10; w++) s = s + 32'(words[w]);
    while (s[31:16] != 16'h0000) s = 32'(s[15:0]) + 32'(s[31:16]);
    return ~s[15:0];
  endfunction

  task automatic put_bytes(input logic [63:0] v, input int n);
    for (int k = n - 1; k >= 0; k--) begin
      exp_bytes[exp_len] = v[8*k +: 8];  // msb first in wire order
      exp_len++;
    end
  endtask

  task automatic build_expected(input int i);
    int          pkt_len;
    logic [15:0] ip_len;
    pkt_len = case_kind[i] ? 58 : 314;
    ip_len  = 16'(pkt_len - 14);
    exp_len = 0;
    put_bytes(64'(case_mac[i]), 6);
    put_bytes(64'(SRC_MAC), 6);
    put_bytes(64'h0800, 2);
    put_bytes(64'({`IPV4_VER_IHL, `IPV4_TOS}), 2);
    put_bytes(64'(ip_len), 2);
    put_bytes(64'({`IPV4_ID, `IPV4_FLAGS}), 4);
    put_bytes(64'({`IPV4_TTL, `IPV4_PROTO_UDP}), 2);
    put_bytes(64'(ip_checksum(ip_len, case_ip[i])), 2);
    put_bytes(64'(SRC_IP), 4);
    put_bytes(64'(case_ip[i]), 4);
    put_bytes(64'({`ROCE_UDP_SPORT, 16'd4791}), 4);
    put_bytes(64'(ip_len - 16'd20), 2);
    put_bytes(64'h0, 2);
    put_bytes(64'(case_kind[i] ? `BTH_OP_ACK : `BTH_OP_RD_RESP_ONLY), 1);
    put_bytes(64'({8'h00, `BTH_PKEY}), 3);
    put_bytes(64'(case_qp[i]), 4);
    put_bytes(64'(case_psn[i]), 4);
    put_bytes(64'h0, 4);  // aeth
    while (exp_len < pkt_len) put_bytes(64'(case_psn[i][7:0]), 1);
  endtask

  task automatic write_context(input int i);
    cfg_we_i  <= 1'b1;
    cfg_qp_i  <= case_qp[i][`QP_IDX_W-1:0];
    cfg_mac_i <= case_mac[i];
    cfg_ip_i  <= case_ip[i];
    @(posedge core_clk);
    cfg_we_i  <= 1'b0;
  endtask

  task automatic send_request(input int i);
    logic [`AXIS_DATA_W-1:0] data;
    for (int b = 0; b < case_beats[i]; b++) begin
      for (int w = 0; w < 16; w++) begin
        req_seed = lcg_next(req_seed);
        data[32*w +: 32] = req_seed;  // junk that trailing beats must not leak
      end
      if (b == 0) begin
        data[47*8 +: 24] = {case_qp[i][7:0], case_qp[i][15:8], case_qp[i][23:16]};
        data[51*8 +: 24] = {case_psn[i][7:0], case_psn[i][15:8], case_psn[i][23:16]};
      end
      req_seed = lcg_next(req_seed);
      if (req_seed[31:30] == 2'b00) begin
        req_valid_i <= 1'b0;
        @(posedge core_clk);
      end
      req_valid_i <= 1'b1;
      req_data_i  <= data;
      req_last_i  <= (b == case_beats[i] - 1);
      req_kind_i  <= (b == 0) ? case_kind[i] : ~case_kind[i];  // only the first beat counts
      @(posedge core_clk);
      while (!req_ready_o) @(posedge core_clk);
    end
    req_valid_i <= 1'b0;
    req_last_i  <= 1'b0;
  endtask

  always @(posedge core_clk) begin
    rdy_seed = lcg_next(rdy_seed);
    tx_tready_i <= (rdy_seed[31:30] != 2'b00);  // roughly one stall in four
  end

  // a beat seen at the falling edge transfers on the next rising edge
  always @(negedge core_clk) begin
    if (core_aresetn && tx_tvalid_o && tx_tready_i) begin
      if (pkt_idx >= NUM_CASES) begin
        errors++;
        $display("output beat arrived after all expected packets were received");
      end else begin
        if (beat_idx == 0) build_expected(pkt_idx);
        base      = beat_idx * 64;
        nlanes    = (exp_len - base > 64) ? 64 : exp_len - base;
        exp_last  = (base + 64 >= exp_len);
        exp_data  = '0;
        exp_keep  = '0;
        lane_mask = '0;
        for (int l = 0; l < nlanes; l++) begin
          exp_data[8*l +: 8]  = exp_bytes[base + l];
          exp_keep[l]         = 1'b1;
          lane_mask[8*l +: 8] = 8'hff;
        end
        compare_value($sformatf("%s beat %0d data", case_name[pkt_idx], beat_idx),
                      exp_data, tx_tdata_o & lane_mask);
        compare_value($sformatf("%s beat %0d tkeep", case_name[pkt_idx], beat_idx),
                      512'(exp_keep), 512'(tx_tkeep_o));
        compare_value($sformatf("%s beat %0d tlast", case_name[pkt_idx], beat_idx),
                      512'(exp_last), 512'(tx_tlast_o));
        if (exp_last) begin
          pkt_idx++;
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
  end

  always @(posedge core_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d packets received",
               cycles, pkt_idx, NUM_CASES);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    core_aresetn = 1'b0;
    req_valid_i  = 1'b0;
    req_data_i   = '0;
    req_last_i   = 1'b0;
    req_kind_i   = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_qp_i     = '0;
    cfg_mac_i    = '0;
    cfg_ip_i     = '0;
    src_mac_i    = SRC_MAC;
    src_ip_i     = SRC_IP;
    tx_tready_i  = 1'b0;
    add_case("rd_qp1", 1'b0, 24'h000001, 24'h000a11, 1, 48'h0200_0000_0001, 32'hc0a8_0001);
    add_case("ack_qp2", 1'b1, 24'h000002, 24'h000b22, 1, 48'h0200_0000_0002, 32'hc0a8_0002);
    add_case("rd_qp5_multi", 1'b0, 24'h012345, 24'habcdef, 3, 48'h0200_0000_0005,
             32'hc0a8_0105);
    add_case("ack_qp7_multi", 1'b1, 24'h000007, 24'h7fffff, 2, 48'h0200_0000_0007,
             32'h0a0a_0a07);
    add_case("rd_qp1_rewrite", 1'b0, 24'h000001, 24'h000c33, 1, 48'h0211_2233_4455,
             32'hac10_2001);
    add_case("rd_qp9_alias", 1'b0, 24'h000009, 24'h123456, 2, 48'h02aa_bbcc_ddee,
             32'h6464_0909);
    add_case("ack_qp0_multi", 1'b1, 24'h000000, 24'hffffff, 4, 48'h0200_0000_0000,
             32'h0101_0101);
    add_case("rd_qp6_carry", 1'b0, 24'h000006, 24'h0000fe, 1, 48'hffff_ffff_fffe,
             32'hffff_ffff);
    // stall factor 8 over descriptor, config and output beats
    for (int i = 0; i < NUM_CASES; i++) begin
      cycle_limit += 8 * (case_beats[i] + (case_kind[i] ? 1 : 5) + 2);
    end
    cycle_limit += 40;
    repeat (2) @(posedge core_clk);
    core_aresetn <= 1'b1;
    @(posedge core_clk);
    for (int i = 0; i < NUM_CASES; i++) begin
      write_context(i);
      send_request(i);
    end
    wait (pkt_idx == NUM_CASES);
    repeat (10) @(posedge core_clk);  // catch stray beats
    $display("%0d errors, %0d of %0d packets checked", errors, pkt_idx, NUM_CASES);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== rdma_resp_pkt_gen_top.f ====
+incdir+.
rdma_pkt_pkg.sv
resp_hdr_if.sv
qp_context_table.sv
ipv4_checksum.sv
resp_hdr_builder.sv
beat_segmenter.sv
rdma_resp_pkt_gen_top.sv
rdma_resp_pkt_gen_asserts.sv
tb_rdma_resp_pkt_gen.sv

// ==== Makefile ====
TOP := tb_rdma_resp_pkt_gen

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f rdma_resp_pkt_gen_top.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
